//--- mips_pkg.sv
/* Shared widths, opcodes, funct codes and pipeline types for the MIPS pipeline.
   Every stage refers to these by scoped names. */

package mips_pkg;

    localparam int data_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int dmem_depth = 64;  // data memory words

    // opcodes
    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_addi  = 6'h08;
    localparam logic [5:0] op_lw    = 6'h23;
    localparam logic [5:0] op_sw    = 6'h2B;

    // funct field of R-type
    localparam logic [5:0] fn_add = 6'h20;
    localparam logic [5:0] fn_sub = 6'h22;
    localparam logic [5:0] fn_and = 6'h24;
    localparam logic [5:0] fn_or  = 6'h25;
    localparam logic [5:0] fn_slt = 6'h2A;

    typedef logic [data_w-1:0]     word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_slt = 3'd4
    } alu_op_t;

    // control bundle carried down the pipe, all zero is a bubble
    typedef struct packed {
        logic    reg_write;    // writes a register
        logic    mem_read;     // lw
        logic    mem_write;    // sw
        logic    mem_to_reg;   // result comes from data memory
        logic    alu_src_imm;  // second operand is the immediate
        logic    reg_dst_rd;   // dest is rd, else rt
        alu_op_t alu_op;       // op for the non R-type forms
    } ctrl_t;

endpackage

//--- instr_fetch.sv
/* Input side of the pipeline. Takes instructions over a valid/ready handshake
   and holds the one in decode, refusing new input while decode is stalled. */

`timescale 1ns/1ps

module instr_fetch (
    input  logic            SYS_clk,
    input  logic            SYS_reset,
    input  logic            instr_valid,
    output logic            instr_ready,
    input  mips_pkg::word_t instr,
    input  logic            stall,
    output logic            f_valid,
    output mips_pkg::word_t f_instr
);

    // only a held instruction can be blocked by a stall
    assign instr_ready = ~(stall & f_valid);

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            f_valid <= 1'b0;
            f_instr <= '0;
        end
        else if (instr_ready)
        begin
            f_valid <= instr_valid;
            f_instr <= instr_valid ? instr : '0;  // zero word when idle
        end
    end

endmodule

//--- reg_file.sv
/* 32 x 32 register file for the decode stage. Two combinational read ports,
   one write port, and a same-cycle write passes through to the reads. */

`timescale 1ns/1ps

module reg_file (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  mips_pkg::reg_addr_t rs_addr,
    input  mips_pkg::reg_addr_t rt_addr,
    output mips_pkg::word_t     rs_data,
    output mips_pkg::word_t     rt_data,
    input  logic                wr_en,
    input  mips_pkg::reg_addr_t wr_addr,
    input  mips_pkg::word_t     wr_data
);

    mips_pkg::word_t regs [2**mips_pkg::reg_addr_w];

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < 2**mips_pkg::reg_addr_w; i++)
                regs[i] <= '0;
        end
        else if (wr_en && wr_addr != '0)
            regs[wr_addr] <= wr_data;
    end

    // $0 is hardwired, writeback data bypasses the array
    assign rs_data = (rs_addr == '0)                  ? '0      :
                     (wr_en && wr_addr == rs_addr)    ? wr_data : regs[rs_addr];
    assign rt_data = (rt_addr == '0)                  ? '0      :
                     (wr_en && wr_addr == rt_addr)    ? wr_data : regs[rt_addr];

endmodule

//--- hazard_unit.sv
/* Data hazard detection for decode. Producers in execute, and loads in memory,
   stall decode; other memory-stage writers are forwarded into decode. */

`timescale 1ns/1ps

module hazard_unit (
    input  mips_pkg::word_t     d_instr,
    input  mips_pkg::ctrl_t     ex_ctrl,
    input  mips_pkg::reg_addr_t ex_dst,
    input  mips_pkg::ctrl_t     mem_ctrl,
    input  mips_pkg::reg_addr_t mem_dst,
    output logic                stall,
    output logic                fwd_rs,
    output logic                fwd_rt
);

    logic [5:0]          opcode;
    mips_pkg::reg_addr_t rs;
    mips_pkg::reg_addr_t rt;
    logic                use_rs;
    logic                use_rt;
    logic                ex_wr;
    logic                mem_wr;
    logic                ex_hit_rs;
    logic                ex_hit_rt;
    logic                mem_hit_rs;
    logic                mem_hit_rt;

    assign opcode = d_instr[31:26];
    assign rs     = d_instr[25:21];
    assign rt     = d_instr[20:16];

    always_comb
    begin
        use_rs = 1'b0;
        use_rt = 1'b0;
        case (opcode)
            mips_pkg::op_rtype:
            begin
                use_rs = 1'b1;
                use_rt = 1'b1;
            end
            mips_pkg::op_sw:
            begin
                use_rs = 1'b1;
                use_rt = 1'b1;   // store data
            end
            mips_pkg::op_addi,
            mips_pkg::op_lw:
                use_rs = 1'b1;
            default:
            begin
                use_rs = 1'b0;
                use_rt = 1'b0;
            end
        endcase
    end

    // writes to $0 never create a dependency
    assign ex_wr  = ex_ctrl.reg_write  && ex_dst  != '0;
    assign mem_wr = mem_ctrl.reg_write && mem_dst != '0;

    assign ex_hit_rs  = ex_wr  && use_rs && (ex_dst  == rs);
    assign ex_hit_rt  = ex_wr  && use_rt && (ex_dst  == rt);
    assign mem_hit_rs = mem_wr && use_rs && (mem_dst == rs);
    assign mem_hit_rt = mem_wr && use_rt && (mem_dst == rt);

    // load data only exists after the memory stage
    assign stall  = ex_hit_rs | ex_hit_rt |
                    (mem_ctrl.mem_read & (mem_hit_rs | mem_hit_rt));
    assign fwd_rs = mem_hit_rs & ~mem_ctrl.mem_read;
    assign fwd_rt = mem_hit_rt & ~mem_ctrl.mem_read;

endmodule

//--- decode_stage.sv
/* Decode stage. Builds the control bundle, reads and forwards the operands,
   and registers them into execute; a stall puts a bubble into execute. */

`timescale 1ns/1ps

module decode_stage (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  logic                f_valid,
    input  mips_pkg::word_t     f_instr,
    input  logic                stall,
    input  logic                fwd_rs,
    input  logic                fwd_rt,
    input  mips_pkg::word_t     mem_alu_result,
    input  logic                wb_reg_write,
    input  mips_pkg::reg_addr_t wb_reg,
    input  mips_pkg::word_t     wb_data,
    output mips_pkg::ctrl_t     ex_ctrl,
    output mips_pkg::reg_addr_t ex_dst,
    output mips_pkg::word_t     ex_rs_val,
    output mips_pkg::word_t     ex_rt_val,
    output mips_pkg::word_t     ex_imm,
    output logic [5:0]          ex_funct
);

    mips_pkg::ctrl_t     d_ctrl;
    mips_pkg::word_t     rs_data;
    mips_pkg::word_t     rt_data;
    mips_pkg::word_t     rs_val;
    mips_pkg::word_t     rt_val;
    mips_pkg::word_t     imm;
    mips_pkg::reg_addr_t dst;

    reg_file u_reg_file (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .rs_addr   (f_instr[25:21]),
        .rt_addr   (f_instr[20:16]),
        .rs_data   (rs_data),
        .rt_data   (rt_data),
        .wr_en     (wb_reg_write),
        .wr_addr   (wb_reg),
        .wr_data   (wb_data)
    );

    always_comb
    begin
        d_ctrl        = '0;
        d_ctrl.alu_op = mips_pkg::alu_add;  // address and addi math
        if (f_valid)
        begin
            case (f_instr[31:26])
                mips_pkg::op_rtype:
                begin
                    d_ctrl.reg_write  = 1'b1;
                    d_ctrl.reg_dst_rd = 1'b1;
                end
                mips_pkg::op_addi:
                begin
                    d_ctrl.reg_write   = 1'b1;
                    d_ctrl.alu_src_imm = 1'b1;
                end
                mips_pkg::op_lw:
                begin
                    d_ctrl.reg_write   = 1'b1;
                    d_ctrl.mem_read    = 1'b1;
                    d_ctrl.mem_to_reg  = 1'b1;
                    d_ctrl.alu_src_imm = 1'b1;
                end
                mips_pkg::op_sw:
                begin
                    d_ctrl.mem_write   = 1'b1;
                    d_ctrl.alu_src_imm = 1'b1;
                end
                default:
                    d_ctrl = '0;  // unknown opcode retires nothing
            endcase
        end
    end

    assign imm    = {{(mips_pkg::data_w-16){f_instr[15]}}, f_instr[15:0]};
    assign dst    = d_ctrl.reg_dst_rd ? f_instr[15:11] : f_instr[20:16];
    assign rs_val = fwd_rs ? mem_alu_result : rs_data;
    assign rt_val = fwd_rt ? mem_alu_result : rt_data;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            ex_ctrl <= '0;
        else if (stall)
            ex_ctrl <= '0;  // bubble
        else
            ex_ctrl <= d_ctrl;
    end

    // payload follows ex_ctrl, ignored under a bubble
    always_ff @(posedge SYS_clk)
    begin
        ex_dst    <= dst;
        ex_rs_val <= rs_val;
        ex_rt_val <= rt_val;
        ex_imm    <= imm;
        ex_funct  <= f_instr[5:0];
    end

endmodule

//--- execute_stage.sv
/* Execute stage. Chooses the ALU operation and second operand, runs the ALU
   and registers the result, store data and destination into memory. */

`timescale 1ns/1ps

module execute_stage (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  mips_pkg::ctrl_t     ex_ctrl,
    input  mips_pkg::reg_addr_t ex_dst,
    input  mips_pkg::word_t     ex_rs_val,
    input  mips_pkg::word_t     ex_rt_val,
    input  mips_pkg::word_t     ex_imm,
    input  logic [5:0]          ex_funct,
    output mips_pkg::ctrl_t     mem_ctrl,
    output mips_pkg::reg_addr_t mem_dst,
    output mips_pkg::word_t     mem_alu_result,
    output mips_pkg::word_t     mem_store_data
);

    mips_pkg::alu_op_t fn_op;
    mips_pkg::alu_op_t alu_op;
    mips_pkg::word_t   alu_b;
    mips_pkg::word_t   alu_y;

    always_comb
    begin
        case (ex_funct)
            mips_pkg::fn_add: fn_op = mips_pkg::alu_add;
            mips_pkg::fn_sub: fn_op = mips_pkg::alu_sub;
            mips_pkg::fn_and: fn_op = mips_pkg::alu_and;
            mips_pkg::fn_or:  fn_op = mips_pkg::alu_or;
            mips_pkg::fn_slt: fn_op = mips_pkg::alu_slt;
            default:          fn_op = mips_pkg::alu_add;
        endcase
    end

    // R-type decodes funct, everything else uses the bundle op
    assign alu_op = ex_ctrl.reg_dst_rd ? fn_op : ex_ctrl.alu_op;
    assign alu_b  = ex_ctrl.alu_src_imm ? ex_imm : ex_rt_val;

    always_comb
    begin
        case (alu_op)
            mips_pkg::alu_add: alu_y = ex_rs_val + alu_b;
            mips_pkg::alu_sub: alu_y = ex_rs_val - alu_b;
            mips_pkg::alu_and: alu_y = ex_rs_val & alu_b;
            mips_pkg::alu_or:  alu_y = ex_rs_val | alu_b;
            mips_pkg::alu_slt: alu_y = {{(mips_pkg::data_w-1){1'b0}},
                                        $signed(ex_rs_val) < $signed(alu_b)};
            default:           alu_y = ex_rs_val + alu_b;
        endcase
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            mem_ctrl <= '0;
        else
            mem_ctrl <= ex_ctrl;
    end

    always_ff @(posedge SYS_clk)
    begin
        mem_dst        <= ex_dst;
        mem_alu_result <= alu_y;
        mem_store_data <= ex_rt_val;  // sw data is rt
    end

endmodule

//--- memory_stage.sv
/* Memory stage. Word-addressed data memory written by sw at the end of the
   stage; lw data is read combinationally and registered into writeback. */

`timescale 1ns/1ps

module memory_stage (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  mips_pkg::ctrl_t     mem_ctrl,
    input  mips_pkg::reg_addr_t mem_dst,
    input  mips_pkg::word_t     mem_alu_result,
    input  mips_pkg::word_t     mem_store_data,
    output mips_pkg::ctrl_t     wb_ctrl,
    output mips_pkg::reg_addr_t wb_dst,
    output mips_pkg::word_t     wb_alu_result,
    output mips_pkg::word_t     wb_load_data
);

    mips_pkg::word_t dmem [mips_pkg::dmem_depth];

    logic [$clog2(mips_pkg::dmem_depth)-1:0] word_addr;

    // byte address in, low two bits dropped
    assign word_addr = mem_alu_result[$clog2(mips_pkg::dmem_depth)+1:2];

    always_ff @(posedge SYS_clk)
    begin
        if (mem_ctrl.mem_write)
            dmem[word_addr] <= mem_store_data;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            wb_ctrl <= '0;
        else
            wb_ctrl <= mem_ctrl;
    end

    always_ff @(posedge SYS_clk)
    begin
        wb_dst        <= mem_dst;
        wb_alu_result <= mem_alu_result;
        if (mem_ctrl.mem_read)
            wb_load_data <= dmem[word_addr];
    end

endmodule

//--- writeback_stage.sv
/* Writeback stage, the output side. Picks load data or the ALU result and
   drives both the register file write and the retire event. */

`timescale 1ns/1ps

module writeback_stage (
    input  mips_pkg::ctrl_t     wb_ctrl,
    input  mips_pkg::reg_addr_t wb_dst,
    input  mips_pkg::word_t     wb_alu_result,
    input  mips_pkg::word_t     wb_load_data,
    output logic                wb_reg_write,
    output mips_pkg::reg_addr_t wb_reg,
    output mips_pkg::word_t     wb_data,
    output logic                retire_valid,
    output mips_pkg::reg_addr_t retire_reg,
    output mips_pkg::word_t     retire_data
);

    assign wb_data      = wb_ctrl.mem_to_reg ? wb_load_data : wb_alu_result;
    assign wb_reg       = wb_dst;
    assign wb_reg_write = wb_ctrl.reg_write && (wb_dst != '0);  // $0 never written

    // one retire per architectural register write
    assign retire_valid = wb_reg_write;
    assign retire_reg   = wb_dst;
    assign retire_data  = wb_data;

endmodule

//--- mips_pipeline.sv
/* Top level of the five-stage integer pipeline. Instructions enter over
   valid/ready, register writes leave as retire events in program order. */

`timescale 1ns/1ps

module mips_pipeline (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  logic                instr_valid,
    output logic                instr_ready,
    input  mips_pkg::word_t     instr,
    output logic                retire_valid,
    output mips_pkg::reg_addr_t retire_reg,
    output mips_pkg::word_t     retire_data
);

    logic                f_valid;
    mips_pkg::word_t     f_instr;
    logic                stall;
    logic                fwd_rs;
    logic                fwd_rt;

    mips_pkg::ctrl_t     ex_ctrl;
    mips_pkg::reg_addr_t ex_dst;
    mips_pkg::word_t     ex_rs_val;
    mips_pkg::word_t     ex_rt_val;
    mips_pkg::word_t     ex_imm;
    logic [5:0]          ex_funct;

    mips_pkg::ctrl_t     mem_ctrl;
    mips_pkg::reg_addr_t mem_dst;
    mips_pkg::word_t     mem_alu_result;
    mips_pkg::word_t     mem_store_data;

    mips_pkg::ctrl_t     wb_ctrl;
    mips_pkg::reg_addr_t wb_dst;
    mips_pkg::word_t     wb_alu_result;
    mips_pkg::word_t     wb_load_data;
    logic                wb_reg_write;
    mips_pkg::reg_addr_t wb_reg;
    mips_pkg::word_t     wb_data;

    instr_fetch u_fetch (
        .SYS_clk     (SYS_clk),
        .SYS_reset   (SYS_reset),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr),
        .stall       (stall),
        .f_valid     (f_valid),
        .f_instr     (f_instr)
    );

    hazard_unit u_hazard (
        .d_instr  (f_instr),
        .ex_ctrl  (ex_ctrl),
        .ex_dst   (ex_dst),
        .mem_ctrl (mem_ctrl),
        .mem_dst  (mem_dst),
        .stall    (stall),
        .fwd_rs   (fwd_rs),
        .fwd_rt   (fwd_rt)
    );

    decode_stage u_decode (
        .SYS_clk        (SYS_clk),
        .SYS_reset      (SYS_reset),
        .f_valid        (f_valid),
        .f_instr        (f_instr),
        .stall          (stall),
        .fwd_rs         (fwd_rs),
        .fwd_rt         (fwd_rt),
        .mem_alu_result (mem_alu_result),  // forward path
        .wb_reg_write   (wb_reg_write),
        .wb_reg         (wb_reg),
        .wb_data        (wb_data),
        .ex_ctrl        (ex_ctrl),
        .ex_dst         (ex_dst),
        .ex_rs_val      (ex_rs_val),
        .ex_rt_val      (ex_rt_val),
        .ex_imm         (ex_imm),
        .ex_funct       (ex_funct)
    );

    execute_stage u_execute (
        .SYS_clk        (SYS_clk),
        .SYS_reset      (SYS_reset),
        .ex_ctrl        (ex_ctrl),
        .ex_dst         (ex_dst),
        .ex_rs_val      (ex_rs_val),
        .ex_rt_val      (ex_rt_val),
        .ex_imm         (ex_imm),
        .ex_funct       (ex_funct),
        .mem_ctrl       (mem_ctrl),
        .mem_dst        (mem_dst),
        .mem_alu_result (mem_alu_result),
        .mem_store_data (mem_store_data)
    );

    memory_stage u_memory (
        .SYS_clk        (SYS_clk),
        .SYS_reset      (SYS_reset),
        .mem_ctrl       (mem_ctrl),
        .mem_dst        (mem_dst),
        .mem_alu_result (mem_alu_result),
        .mem_store_data (mem_store_data),
        .wb_ctrl        (wb_ctrl),
        .wb_dst         (wb_dst),
        .wb_alu_result  (wb_alu_result),
        .wb_load_data   (wb_load_data)
    );

    writeback_stage u_writeback (
        .wb_ctrl       (wb_ctrl),
        .wb_dst        (wb_dst),
        .wb_alu_result (wb_alu_result),
        .wb_load_data  (wb_load_data),
        .wb_reg_write  (wb_reg_write),
        .wb_reg        (wb_reg),
        .wb_data       (wb_data),
        .retire_valid  (retire_valid),
        .retire_reg    (retire_reg),
        .retire_data   (retire_data)
    );

endmodule

//--- tb_mips_pipeline.sv
/* Testbench for the MIPS pipeline. Builds a program table with a sequential
   reference model, streams it in with random gaps and checks every retire. */

`timescale 1ns/1ps

module tb_mips_pipeline;

    localparam int accept_timeout = 40;  // cycles waiting on instr_ready
    localparam int retire_timeout = 60;  // idle cycles between retires
    localparam int drain_cycles   = 20;

    logic                SYS_clk;
    logic                SYS_reset;
    logic                instr_valid;
    logic                instr_ready;
    mips_pkg::word_t     instr;
    logic                retire_valid;
    mips_pkg::reg_addr_t retire_reg;
    mips_pkg::word_t     retire_data;

    // program table, one entry per instruction
    mips_pkg::word_t     prog_instr [$];
    logic                prog_wr    [$];  // low for sw and writes to $0
    mips_pkg::reg_addr_t prog_reg   [$];
    mips_pkg::word_t     prog_val   [$];

    // architectural state of the reference model
    mips_pkg::word_t ref_regs [32];
    mips_pkg::word_t ref_mem  [mips_pkg::dmem_depth];

    logic [31:0] lcg_state;
    int          err_count;
    int          timeout_count;
    int          retired;
    int          expected_retires;

    mips_pipeline DUT (
        .SYS_clk      (SYS_clk),
        .SYS_reset    (SYS_reset),
        .instr_valid  (instr_valid),
        .instr_ready  (instr_ready),
        .instr        (instr),
        .retire_valid (retire_valid),
        .retire_reg   (retire_reg),
        .retire_data  (retire_data)
    );

    always #50 SYS_clk = ~SYS_clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic mips_pkg::word_t r_instr(logic [5:0] fn, int rd, int rs, int rt);
        return {mips_pkg::op_rtype, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    // operand order as in "addi rt, rs, imm"
    function automatic mips_pkg::word_t i_instr(logic [5:0] op, int rt, int rs, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    task automatic check_reg(input string name, input mips_pkg::reg_addr_t got,
                             input mips_pkg::reg_addr_t exp);
        if (got !== exp)
        begin
            err_count++;
            $display("ERR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_word(input string name, input mips_pkg::word_t got,
                              input mips_pkg::word_t exp);
        if (got !== exp)
        begin
            err_count++;
            $display("ERR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic expect_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            err_count++;
            $display("ERR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    // runs one instruction on the model and appends it with its expected retire
    task automatic add_instr(input mips_pkg::word_t ins);
        mips_pkg::reg_addr_t rs;
        mips_pkg::reg_addr_t rt;
        mips_pkg::reg_addr_t dst;
        mips_pkg::word_t     a;
        mips_pkg::word_t     b;
        mips_pkg::word_t     imm;
        mips_pkg::word_t     val;
        logic [5:0]          widx;
        logic                wr;
        rs   = ins[25:21];
        rt   = ins[20:16];
        a    = ref_regs[rs];
        b    = ref_regs[rt];
        imm  = {{16{ins[15]}}, ins[15:0]};
        widx = 6'((a + imm) >> 2);  // byte address to word index
        wr   = 1'b0;
        dst  = rt;
        val  = '0;
        case (ins[31:26])
            mips_pkg::op_rtype:
            begin
                wr  = 1'b1;
                dst = ins[15:11];
                case (ins[5:0])
                    mips_pkg::fn_sub: val = a - b;
                    mips_pkg::fn_and: val = a & b;
                    mips_pkg::fn_or:  val = a | b;
                    mips_pkg::fn_slt: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:          val = a + b;
                endcase
            end
            mips_pkg::op_addi:
            begin
                wr  = 1'b1;
                val = a + imm;
            end
            mips_pkg::op_lw:
            begin
                wr  = 1'b1;
                val = ref_mem[widx];
            end
            mips_pkg::op_sw:
                ref_mem[widx] = b;
            default:
                wr = 1'b0;
        endcase
        if (dst == '0)
            wr = 1'b0;  // $0 stays zero, no retire
        if (wr)
            ref_regs[dst] = val;
        prog_instr.push_back(ins);
        prog_wr.push_back(wr);
        prog_reg.push_back(dst);
        prog_val.push_back(val);
    endtask

    task automatic build_program();
        logic [31:0] r;
        logic [5:0]  fn;
        foreach (ref_regs[i])
            ref_regs[i] = '0;
        // operands, then independent ALU ops
        add_instr(i_instr(mips_pkg::op_addi, 1, 0, 25));
        add_instr(i_instr(mips_pkg::op_addi, 2, 0, -7));
        add_instr(i_instr(mips_pkg::op_addi, 3, 0, 240));
        add_instr(i_instr(mips_pkg::op_addi, 4, 0, 60));
        add_instr(r_instr(mips_pkg::fn_add, 5, 1, 2));
        add_instr(r_instr(mips_pkg::fn_sub, 6, 3, 4));
        add_instr(r_instr(mips_pkg::fn_and, 7, 3, 4));
        add_instr(r_instr(mips_pkg::fn_or, 8, 1, 4));
        add_instr(r_instr(mips_pkg::fn_slt, 9, 2, 1));
        add_instr(r_instr(mips_pkg::fn_slt, 10, 1, 2));
        add_instr(i_instr(mips_pkg::op_addi, 11, 1, -100));
        // dependent chains one and two apart
        add_instr(r_instr(mips_pkg::fn_add, 12, 5, 6));
        add_instr(r_instr(mips_pkg::fn_sub, 13, 12, 1));
        add_instr(r_instr(mips_pkg::fn_or, 14, 13, 12));
        add_instr(i_instr(mips_pkg::op_addi, 15, 14, -1));
        add_instr(r_instr(mips_pkg::fn_and, 16, 15, 14));
        // stores and loads, with load-use cases
        add_instr(i_instr(mips_pkg::op_addi, 17, 0, 16));
        add_instr(i_instr(mips_pkg::op_sw, 14, 17, 0));
        add_instr(i_instr(mips_pkg::op_sw, 16, 17, 4));
        add_instr(i_instr(mips_pkg::op_lw, 18, 17, 0));
        add_instr(r_instr(mips_pkg::fn_add, 19, 18, 18));
        add_instr(i_instr(mips_pkg::op_lw, 20, 17, 4));
        add_instr(i_instr(mips_pkg::op_sw, 20, 17, 8));
        add_instr(i_instr(mips_pkg::op_lw, 21, 17, 8));
        add_instr(r_instr(mips_pkg::fn_slt, 22, 21, 2));
        add_instr(i_instr(mips_pkg::op_addi, 0, 1, 5));  // no retire
        add_instr(r_instr(mips_pkg::fn_add, 23, 0, 22));
        // random R-type tail into $24..$31
        for (int k = 0; k < 10; k++)
        begin
            r = lcg_next();
            case (r[26:24])
                3'd1:    fn = mips_pkg::fn_sub;
                3'd2:    fn = mips_pkg::fn_and;
                3'd3:    fn = mips_pkg::fn_or;
                3'd4:    fn = mips_pkg::fn_slt;
                default: fn = mips_pkg::fn_add;
            endcase
            add_instr(r_instr(fn, 24 + int'(r[2:0]), int'(r[9:5]), int'(r[14:10])));
        end
    endtask

    task automatic drive_program();
        logic [31:0] r;
        int          gap;
        int          waited;
        logic        accepted;
        for (int i = 0; i < prog_instr.size(); i++)
        begin
            r   = lcg_next();
            gap = r[29] ? 0 : int'(r[31:30]);
            for (int g = 0; g < gap; g++)
            begin
                @(posedge SYS_clk);
                #1;
            end
            instr_valid = 1'b1;
            instr       = prog_instr[i];
            accepted    = 1'b0;
            waited      = 0;
            while (!accepted && waited < accept_timeout)
            begin
                @(negedge SYS_clk);
                accepted = instr_ready;  // transfer on the coming edge
                @(posedge SYS_clk);
                #1;
                waited++;
            end
            instr_valid = 1'b0;
            if (!accepted)
            begin
                timeout_count++;
                $display("timeout: instruction %0d was never accepted", i);
                break;
            end
        end
    endtask

    task automatic watch_retires();
        int pidx;
        int idle;
        pidx = 0;
        idle = 0;
        while (retired < expected_retires && idle < retire_timeout)
        begin
            @(negedge SYS_clk);
            if (retire_valid)
            begin
                while (!prog_wr[pidx])
                    pidx++;  // skip sw and $0 writes
                check_reg("retire_reg", retire_reg, prog_reg[pidx]);
                check_word("retire_data", retire_data, prog_val[pidx]);
                pidx++;
                retired++;
                idle = 0;
            end
            else
                idle++;
        end
        if (retired < expected_retires)
        begin
            timeout_count++;
            $display("timeout: only %0d of %0d retire events seen", retired, expected_retires);
        end
        else
        begin
            for (int c = 0; c < drain_cycles; c++)
            begin
                @(negedge SYS_clk);
                if (retire_valid)
                begin
                    err_count++;
                    $display("extra retire event for register %0d after the program", retire_reg);
                end
            end
        end
    endtask

    initial
    begin
        SYS_clk          = 1'b0;
        SYS_reset        = 1'b1;
        instr_valid      = 1'b0;
        instr            = '0;
        lcg_state        = 32'h3753;
        err_count        = 0;
        timeout_count    = 0;
        retired          = 0;
        expected_retires = 0;
        build_program();
        foreach (prog_wr[i])
            if (prog_wr[i])
                expected_retires++;
        repeat (10) @(posedge SYS_clk);
        #1;
        SYS_reset = 1'b0;
        // idle pipe after reset
        for (int c = 0; c < 4; c++)
        begin
            @(negedge SYS_clk);
            expect_flag("instr_ready", instr_ready, 1'b1);
            expect_flag("retire_valid", retire_valid, 1'b0);
        end
        @(posedge SYS_clk);
        #1;
        fork
            drive_program();
            watch_retires();
        join
        $display("errors %0d, timeouts %0d, retired %0d of %0d",
                 err_count, timeout_count, retired, expected_retires);
        if (err_count == 0 && timeout_count == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- verilog.f
mips_pkg.sv
instr_fetch.sv
reg_file.sv
hazard_unit.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
writeback_stage.sv
mips_pipeline.sv
tb_mips_pipeline.sv

//--- Makefile
# Verilator build and run of the MIPS pipeline testbench

TOP = tb_mips_pipeline
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -f verilog.f -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@grep -q "RESULT: PASS" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf obj_dir $(LOG)
